//--- gearbox_pkg.sv
`default_nettype none

package gearbox_pkg;

    // datapath widths
    localparam int dram_width = 288;
    localparam int tge_width = 256;
    localparam int beats_per_block = 8;
    localparam int words_per_block = 9;
    localparam int residue_step = 32;
    localparam int merge_width = 2 * tge_width;
    localparam int beat_cnt_width = $clog2(beats_per_block);

    // block count register and the beat budget derived from it
    localparam int blocks_width = 16;
    localparam int beat_budget_width = blocks_width + beat_cnt_width;

    // apb register map
    localparam int apb_addr_width = 8;
    localparam logic [apb_addr_width-1:0] addr_ctrl = 8'h00;
    localparam logic [apb_addr_width-1:0] addr_blocks = 8'h04;
    localparam logic [apb_addr_width-1:0] addr_status = 8'h08;
    localparam logic [apb_addr_width-1:0] addr_words_sent = 8'h0c;

    typedef struct packed {
        logic [dram_width-1:0] data;
        logic valid;
    } dram_beat_t;

    typedef struct packed {
        logic [tge_width-1:0] data;
        logic valid;
        logic last;
    } tge_word_t;

    typedef struct packed {
        logic enable;
        logic start;
        logic [blocks_width-1:0] blocks;
    } gearbox_cfg_t;

endpackage

`default_nettype wire

//--- gearbox_apb_regs.sv
`default_nettype none

module gearbox_apb_regs (
    input  wire clk,
    input  wire rst,
    input  wire [gearbox_pkg::apb_addr_width-1:0] paddr,
    input  wire psel,
    input  wire penable,
    input  wire pwrite,
    input  wire [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output gearbox_pkg::gearbox_cfg_t cfg,
    input  wire busy,
    input  wire [31:0] words_sent
);
    import gearbox_pkg::*;

    logic enable_q;
    logic start_q;
    logic busy_q;
    logic done_q;
    logic [blocks_width-1:0] blocks_q;
    logic access;
    logic mapped;
    logic wr_ctrl;
    logic wr_blocks;

    assign access = psel && penable;
    assign wr_ctrl = access && pwrite && (paddr == addr_ctrl);
    assign wr_blocks = access && pwrite && (paddr == addr_blocks);

    // zero wait states
    assign pready = 1'b1;
    assign pslverr = access && !mapped;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            addr_ctrl: prdata = {31'b0, enable_q};
            addr_blocks: prdata = 32'(blocks_q);
            addr_status: prdata = {30'b0, done_q, busy};
            addr_words_sent: prdata = words_sent;
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b0;
            start_q <= 1'b0;
            blocks_q <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            // bit 1 of ctrl is self clearing
            start_q <= wr_ctrl && pwdata[1];
            if (wr_ctrl) begin
                enable_q <= pwdata[0];
            end
            if (wr_blocks) begin
                blocks_q <= pwdata[blocks_width-1:0];
            end

            // sticky done, set on the falling edge of busy
            busy_q <= busy;
            if (start_q) begin
                done_q <= 1'b0;
            end else if (busy_q && !busy) begin
                done_q <= 1'b1;
            end
        end
    end

    assign cfg = '{enable: enable_q, start: start_q, blocks: blocks_q};

endmodule

`default_nettype wire

//--- dram_beat_reader.sv
`default_nettype none

module dram_beat_reader (
    input  wire clk,
    input  wire rst,
    input  wire gearbox_pkg::gearbox_cfg_t cfg,
    input  wire [gearbox_pkg::dram_width-1:0] dram_data,
    input  wire dram_valid,
    input  wire dram_ready,
    output logic dram_request,
    output gearbox_pkg::dram_beat_t beat,
    input  wire beat_ready,
    input  wire block_done,
    output logic busy
);
    import gearbox_pkg::*;

    logic [beat_budget_width-1:0] beats_left;
    logic [blocks_width-1:0] blocks_left;
    logic outstanding;
    logic launch;

    // a start while a transfer runs is dropped
    assign launch = cfg.start && cfg.enable && !busy && (cfg.blocks != '0);

    // busy until the buffer has handed over the last word of the last block
    assign busy = (blocks_left != '0);

    // one read in flight at most, and only when the buffer can take the beat
    assign dram_request = cfg.enable && (beats_left != '0) && !outstanding
                          && beat_ready && dram_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
            blocks_left <= '0;
            outstanding <= 1'b0;
        end else begin
            if (launch) begin
                beats_left <= beat_budget_width'(cfg.blocks)
                              * beat_budget_width'(beats_per_block);
                blocks_left <= cfg.blocks;
            end else begin
                if (dram_request) begin
                    beats_left <= beats_left - 1'b1;
                end
                if (block_done && busy) begin
                    blocks_left <= blocks_left - 1'b1;
                end
            end

            if (dram_request) begin
                outstanding <= 1'b1;
            end else if (dram_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

    // fifo data comes back a fixed cycle after the strobe
    assign beat = '{data: dram_data, valid: dram_valid && outstanding};

endmodule

`default_nettype wire

//--- dram2tge.sv
`default_nettype none

module dram2tge (
    input  wire clk,
    input  wire rst,
    input  wire gearbox_pkg::dram_beat_t beat,
    output logic beat_ready,
    output gearbox_pkg::tge_word_t word,
    input  wire word_ready,
    output logic block_done
);
    import gearbox_pkg::*;

    logic [beat_cnt_width-1:0] beat_cnt;
    logic flush_q;

    // output word register
    logic word_valid;
    logic word_last;
    logic [tge_width-1:0] word_data;

    // leftover upper bits of the previous beats, lsb aligned
    logic [tge_width-1:0] residue_q;
    logic [tge_width-1:0] residue_in;
    logic [merge_width-1:0] merged;

    logic can_load;
    logic take_beat;
    logic take_flush;
    logic last_beat;

    assign can_load = !word_valid || word_ready;
    assign last_beat = (beat_cnt == beat_cnt_width'(beats_per_block - 1));

    // stall while a word waits on the consumer and while the residue drains
    assign beat_ready = can_load && !flush_q;
    assign take_beat = beat.valid && beat_ready;
    assign take_flush = flush_q && can_load;

    // first beat of a block starts with an empty residue
    assign residue_in = (beat_cnt == '0) ? '0 : residue_q;

    // beat j lands above the 32*j residue bits
    //   low half is the next word, high half is the new residue
    assign merged = (merge_width'(beat.data) << (beat_cnt * residue_step))
                    | merge_width'(residue_in);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
            flush_q <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (take_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
                word_valid <= 1'b1;
                if (last_beat) begin
                    flush_q <= 1'b1;
                end
            end else if (take_flush) begin
                flush_q <= 1'b0;
                word_valid <= 1'b1;
            end else if (word_ready) begin
                word_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_beat) begin
            word_data <= merged[tge_width-1:0];
            word_last <= 1'b0;
            residue_q <= merged[merge_width-1:tge_width];
        end else if (take_flush) begin
            // after beat 7 the residue is a full word
            word_data <= residue_q;
            word_last <= 1'b1;
        end
    end

    assign word = '{data: word_data, valid: word_valid, last: word_last};

    // ninth word of the block handed over
    assign block_done = word_valid && word_last && word_ready;

endmodule

`default_nettype wire

//--- tge_frame_sender.sv
`default_nettype none

module tge_frame_sender (
    input  wire clk,
    input  wire rst,
    input  wire gearbox_pkg::tge_word_t word,
    output logic word_ready,
    output gearbox_pkg::tge_word_t tge,
    input  wire tge_ready,
    output logic [31:0] words_sent
);
    import gearbox_pkg::*;

    logic out_valid;
    logic out_last;
    logic [tge_width-1:0] out_data;
    logic take;

    // single output stage, refilled on the cycle it drains
    assign word_ready = !out_valid || tge_ready;
    assign take = word.valid && word_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (word_ready) begin
            out_valid <= word.valid;
        end
    end

    // last rides along so the block end shows on the port
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= word.data;
            out_last <= word.last;
        end
    end

    // sent words since reset, a new start keeps counting
    always_ff @(posedge clk) begin
        if (rst) begin
            words_sent <= '0;
        end else if (out_valid && tge_ready) begin
            words_sent <= words_sent + 1'b1;
        end
    end

    assign tge = '{data: out_data, valid: out_valid, last: out_last};

endmodule

`default_nettype wire

//--- tge_gearbox_top.sv
`default_nettype none

module tge_gearbox_top (
    input  wire clk,
    input  wire rst,
    input  wire [gearbox_pkg::apb_addr_width-1:0] paddr,
    input  wire psel,
    input  wire penable,
    input  wire pwrite,
    input  wire [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    input  wire [gearbox_pkg::dram_width-1:0] dram_data,
    input  wire dram_valid,
    output logic dram_request,
    input  wire dram_ready,
    output gearbox_pkg::tge_word_t tge,
    input  wire tge_ready
);
    import gearbox_pkg::*;

    gearbox_cfg_t cfg;
    dram_beat_t beat;
    tge_word_t word;
    logic beat_ready;
    logic word_ready;
    logic block_done;
    logic busy;
    logic [31:0] words_sent;

    gearbox_apb_regs regs0 (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cfg(cfg), .busy(busy), .words_sent(words_sent)
    );

    dram_beat_reader reader0 (
        .clk(clk), .rst(rst), .cfg(cfg),
        .dram_data(dram_data), .dram_valid(dram_valid), .dram_ready(dram_ready),
        .dram_request(dram_request), .beat(beat), .beat_ready(beat_ready),
        .block_done(block_done), .busy(busy)
    );

    dram2tge gearbox0 (
        .clk(clk), .rst(rst), .beat(beat), .beat_ready(beat_ready),
        .word(word), .word_ready(word_ready), .block_done(block_done)
    );

    tge_frame_sender sender0 (
        .clk(clk), .rst(rst), .word(word), .word_ready(word_ready),
        .tge(tge), .tge_ready(tge_ready), .words_sent(words_sent)
    );

endmodule

`default_nettype wire

//--- tge_gearbox_properties.sv
`default_nettype none

module tge_gearbox_properties (
    input wire clk,
    input wire rst,
    input wire gearbox_pkg::dram_beat_t beat,
    input wire beat_ready,
    input wire gearbox_pkg::tge_word_t word,
    input wire word_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // held word keeps valid and data until taken
    word_stable: assert property (@(posedge clk) disable iff (rst)
        word.valid && !word_ready |=> word.valid && $stable(word.data))
        else $error("word changed while held");

    // a returning beat always finds the buffer ready, so none is dropped
    beat_never_refused: assert property (@(posedge clk) disable iff (rst)
        beat.valid |-> beat_ready)
        else $error("beat arrived while beat_ready was low");

    // output register cleared by reset
    valid_low_after_reset: assert property (@(posedge clk) rst |=> !word.valid)
        else $error("word valid in the cycle after reset");

endmodule

bind dram2tge tge_gearbox_properties props0 (
    .clk(clk),
    .rst(rst),
    .beat(beat),
    .beat_ready(beat_ready),
    .word(word),
    .word_ready(word_ready)
);

`default_nettype wire

//--- tb_tge_gearbox.sv
`default_nettype none

module tb_tge_gearbox;
    timeunit 1ns;
    timeprecision 1ps;
    import gearbox_pkg::*;

    logic clk;
    logic rst;
    logic [apb_addr_width-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [dram_width-1:0] dram_data;
    logic dram_valid;
    logic dram_request;
    logic dram_ready;
    tge_word_t tge;
    logic tge_ready;

    logic [31:0] lfsr;
    logic [dram_width-1:0] beats[$];
    logic req_seen;
    logic random_ready;
    logic ready_mode;
    int words_seen;
    int words_target;

    tge_gearbox_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hd000_0001 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [dram_width-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // word n of the whole run, bit sequential over the 8 beats of its block
    function automatic logic [tge_width-1:0] expected_word(input int n);
        logic [dram_width*beats_per_block-1:0] stream;
        int first;
        stream = '0;
        first = (n / words_per_block) * beats_per_block;
        for (int j = 0; j < beats_per_block; j++) begin
            if (first + j < beats.size()) begin
                stream[dram_width*j +: dram_width] = beats[first + j];
            end
        end
        return stream[tge_width*(n % words_per_block) +: tge_width];
    endfunction

    task automatic fail_now();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [tge_width-1:0] got,
                               input logic [tge_width-1:0] want, input string what);
        if (got !== want) begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, want);
            fail_now();
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // setup then access, data sampled mid access cycle
    task automatic apb_cycle(input logic [7:0] addr, input logic write, input logic [31:0] data,
                             output logic [31:0] rdata, output logic err);
        int n;
        paddr = addr;
        pwrite = write;
        pwdata = data;
        psel = 1'b1;
        penable = 1'b0;
        step_cycles(1);
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready) begin
            n++;
            if (n > 16) begin
                $display("timeout: pready never came on the apb bus");
                fail_now();
            end
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        step_cycles(1);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused_data;
        logic unused_err;
        apb_cycle(addr, 1'b1, data, unused_data, unused_err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_cycle(addr, 1'b0, 32'h0, data, err);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_equal(dram_request, 1'b0, "dram_request while idle");
            check_equal(tge.valid, 1'b0, "tge valid while idle");
        end
        step_cycles(1);
    endtask

    task automatic start_blocks(input int blocks);
        words_target += blocks * words_per_block;
        apb_write(addr_blocks, blocks);
        apb_write(addr_ctrl, 32'h3);
    endtask

    task automatic wait_finish();
        logic [31:0] status;
        logic err;
        int n;
        status = '0;
        n = 0;
        while (!status[1]) begin
            apb_read(addr_status, status, err);
            n++;
            if (n > 500) begin
                $display("timeout: done bit never set in the status register");
                fail_now();
            end
        end
        check_equal(status[0], 1'b0, "busy with done set");
        n = 0;
        while (words_seen < words_target) begin
            step_cycles(1);
            n++;
            if (n > 200) begin
                $display("timeout: transmit port stopped short of the expected words");
                fail_now();
            end
        end
        apb_read(addr_words_sent, status, err);
        check_equal(status, words_target, "words_sent register");
        check_equal(words_seen, words_target, "words seen on tge");
    endtask

    always @(negedge clk) begin
        req_seen = dram_request;
        ready_mode = random_ready;
    end

    // fifo answers a strobe one cycle later, tge_ready mostly high when random
    always @(posedge clk) begin : fifo_model
        logic [dram_width-1:0] bits;
        #1;
        dram_valid = req_seen;
        if (req_seen) begin
            take_bits(dram_width, bits);
            beats.push_back(bits);
            dram_data = bits;
        end
        if (ready_mode) begin
            take_bits(2, bits);
            tge_ready = bits[0] | bits[1];
        end else begin
            tge_ready = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (!rst && tge.valid && tge_ready) begin
            check_equal(tge.data, expected_word(words_seen),
                        $sformatf("data of word %0d", words_seen));
            check_equal(tge.last, (words_seen % words_per_block) == words_per_block - 1,
                        $sformatf("last of word %0d", words_seen));
            words_seen++;
        end
    end

    initial begin
        logic [31:0] rdata;
        logic err;
        lfsr = 32'h5ba3_1599;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        dram_data = '0;
        dram_valid = 1'b0;
        dram_ready = 1'b1;
        tge_ready = 1'b1;
        random_ready = 1'b0;
        ready_mode = 1'b0;
        req_seen = 1'b0;
        words_seen = 0;
        words_target = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_quiet(10);
        apb_read(addr_status, rdata, err);
        check_equal(rdata, 32'h0, "status after reset");

        start_blocks(1);
        wait_finish();

        random_ready = 1'b1;
        start_blocks(3);
        wait_finish();

        // unmapped read, then a start with enable clear
        apb_read(8'h10, rdata, err);
        check_equal(err, 1'b1, "pslverr on unmapped address");
        apb_write(addr_blocks, 32'h1);
        apb_write(addr_ctrl, 32'h2);
        expect_quiet(30);

        dram_ready = 1'b0;
        start_blocks(1);
        expect_quiet(20);
        dram_ready = 1'b1;
        wait_finish();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
gearbox_pkg.sv
gearbox_apb_regs.sv
dram_beat_reader.sv
dram2tge.sv
tge_frame_sender.sv
tge_gearbox_top.sv
tge_gearbox_properties.sv
tb_tge_gearbox.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_tge_gearbox -f sources.f -o sim_tge &&
./obj_dir/sim_tge ||
{ echo "simulation run failed"; exit 1; }
